//--- compile.f
src/isa_pkg.sv
src/ooo_pkg.sv
src/issue_if.sv
src/issue_unit.sv
src/reg_status_file.sv
src/reorder_buffer.sv
src/alu_station.sv
src/ooo_core_top.sv
bench/ooo_core_assert.sv
bench/tb_ooo_core.sv

//--- run_sim.sh
#!/bin/sh
# build and run the ooo core testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert -j 0 --top-module tb_ooo_core -f compile.f
./obj_dir/Vtb_ooo_core | tee sim.log

if grep -qx "TEST PASS" sim.log; then
  echo "simulation passed"
  exit 0
fi
echo "simulation failed"
exit 1

//--- bench/tb_ooo_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_ooo_core;

  localparam int N_RANDOM = 200;
  localparam logic [6:0] LOAD_OPC   = 7'b0000011;  // not handled by the core
  localparam logic [6:0] BRANCH_OPC = 7'b1100011;

  logic               clk_100mhz;
  logic               sys_rst;
  logic               i_inst_valid;
  ooo_pkg::word_t     i_inst;
  logic               o_inst_ready;
  logic               o_commit_valid;
  ooo_pkg::reg_addr_t o_commit_rd;
  ooo_pkg::word_t     o_commit_value;

  ooo_pkg::word_t model_regs [32];
  logic [36:0]    expected [$];   // {rd, value} in acceptance order
  logic [36:0]    exp_head;
  ooo_pkg::word_t prog_inst [$];
  int             prog_gap [$];   // idle cycles after each instruction
  int             planned;
  int             errors;
  int             commits;

  ooo_core_top i_dut (.*);

  always #5 clk_100mhz = ~clk_100mhz;

  function automatic ooo_pkg::word_t enc_op(input int f3, input bit alt, input int rd,
                                            input int rs1, input int rs2);
    return {1'b0, alt, 5'b0, rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], isa_pkg::OP};
  endfunction

  function automatic ooo_pkg::word_t enc_imm(input int f3, input int imm, input int rd,
                                             input int rs1);
    return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], isa_pkg::OPIMM};
  endfunction

  function automatic ooo_pkg::word_t enc_lui(input int imm20, input int rd);
    return {imm20[19:0], rd[4:0], isa_pkg::LUI};
  endfunction

  function automatic ooo_pkg::word_t enc_nop(input logic [6:0] opc);
    ooo_pkg::word_t bits;
    bits = $urandom();
    return {bits[31:7], opc};
  endfunction

  // rv32i semantics on the model register file
  function automatic ooo_pkg::word_t model_result(input ooo_pkg::word_t inst);
    ooo_pkg::word_t a;
    ooo_pkg::word_t b;
    a = model_regs[inst[19:15]];
    b = (inst[6:0] == isa_pkg::OP) ? model_regs[inst[24:20]] : {{20{inst[31]}}, inst[31:20]};
    if (inst[6:0] == isa_pkg::LUI) begin
      return {inst[31:12], 12'h000};
    end
    case (inst[14:12])
      3'd0:    return (inst[6:0] == isa_pkg::OP && inst[30]) ? a - b : a + b;
      3'd1:    return a << b[4:0];
      3'd2:    return {31'd0, $signed(a) < $signed(b)};
      3'd3:    return {31'd0, a < b};
      3'd4:    return a ^ b;
      3'd5:    return inst[30] ? ooo_pkg::word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'd6:    return a | b;
      default: return a & b;
    endcase
  endfunction

  task automatic record_accept(input ooo_pkg::word_t inst);
    ooo_pkg::word_t res;
    if (inst[6:0] != isa_pkg::OP && inst[6:0] != isa_pkg::OPIMM && inst[6:0] != isa_pkg::LUI) begin
      return;  // nops never commit
    end
    res = model_result(inst);
    expected.push_back({inst[11:7], res});
    if (inst[11:7] != 5'd0) begin
      model_regs[inst[11:7]] = res;
    end
  endtask

  task automatic add_item(input ooo_pkg::word_t inst, input int gap);
    prog_inst.push_back(inst);
    prog_gap.push_back(gap);
  endtask

  // called 1 ns after a rising edge, returns at the same phase
  task automatic send(input ooo_pkg::word_t inst, input int gap);
    i_inst_valid = 1'b1;
    i_inst       = inst;
    @(negedge clk_100mhz);
    while (!o_inst_ready) begin
      @(negedge clk_100mhz);  // hold under back-pressure
    end
    record_accept(inst);
    @(posedge clk_100mhz);
    #1;
    i_inst_valid = 1'b0;
    repeat (gap) begin
      @(posedge clk_100mhz);
      #1;
    end
  endtask

  task automatic build_directed();
    add_item(enc_lui(20'h12345, 1), 0);
    add_item(enc_imm(0, -7, 2, 0), 0);
    add_item(enc_imm(0, 5, 3, 0), 0);
    for (int f3 = 0; f3 < 8; f3++) begin
      add_item(enc_op(f3, 1'b0, 8 + f3, 2, 3), 0);
      add_item(enc_imm(f3, 3, 16 + f3, 2), 0);
    end
    add_item(enc_op(0, 1'b1, 24, 2, 3), 0);       // sub
    add_item(enc_op(5, 1'b1, 25, 2, 3), 0);       // sra
    add_item(enc_imm(5, 1024 + 3, 26, 2), 0);     // srai
    // dependent chains, every source is the previous rd
    for (int k = 0; k < 6; k++) begin
      add_item(enc_imm(0, k + 1, 5, 5), 0);
    end
    for (int k = 0; k < 4; k++) begin
      add_item(enc_op(0, 1'b0, 6, 6, 5), 0);
    end
    add_item(enc_op(4, 1'b0, 6, 6, 1), 0);
    // x0 as destination, then as source
    add_item(enc_imm(0, 9, 0, 3), 0);
    add_item(enc_op(0, 1'b0, 7, 0, 3), 0);
    add_item(enc_lui(20'hfffff, 0), 0);
    add_item(enc_op(6, 1'b0, 7, 7, 0), 0);
    // unsupported opcodes between real work
    add_item(enc_lui(20'h00abc, 9), 0);
    add_item(enc_nop(LOAD_OPC), 0);
    add_item(enc_imm(0, 1, 9, 9), 0);
    add_item(enc_nop(BRANCH_OPC), 0);
    add_item(enc_nop(LOAD_OPC), 0);
    add_item(enc_op(4, 1'b0, 10, 9, 1), 1);
  endtask

  task automatic build_random(input int n);
    int  kind;
    int  f3;
    int  shamt;
    bit  alt;
    int  gap;
    ooo_pkg::word_t inst;
    for (int k = 0; k < n; k++) begin
      kind  = $urandom_range(9, 0);
      f3    = $urandom_range(7, 0);
      shamt = $urandom_range(31, 0);
      alt   = ($urandom_range(1, 0) == 1);
      if (kind == 0) begin
        inst = enc_nop(BRANCH_OPC);
      end else if (kind == 1) begin
        inst = enc_lui($urandom_range(20'hfffff, 0), $urandom_range(3, 0));
      end else if (kind < 6) begin
        inst = enc_op(f3, alt && (f3 == 0 || f3 == 5), $urandom_range(3, 0),
                      $urandom_range(3, 0), $urandom_range(3, 0));
      end else if (f3 == 1 || f3 == 5) begin
        inst = enc_imm(f3, (alt && f3 == 5) ? 1024 + shamt : shamt, $urandom_range(3, 0),
                       $urandom_range(3, 0));
      end else begin
        inst = enc_imm(f3, $urandom_range(4095, 0), $urandom_range(3, 0), $urandom_range(3, 0));
      end
      gap = ($urandom_range(3, 0) == 0) ? $urandom_range(3, 1) : 0;  // mostly back to back
      add_item(inst, gap);
    end
  endtask

  // commit checker, sampled mid-cycle
  always @(negedge clk_100mhz) begin
    if (!sys_rst && o_commit_valid) begin
      commits++;
      assert (expected.size() != 0) else begin
        errors++;
        $display("commit at %0t to rd %0d but no instruction was pending", $time, o_commit_rd);
      end
      if (expected.size() != 0) begin
        exp_head = expected.pop_front();
        assert (o_commit_rd == exp_head[36:32] && o_commit_value == exp_head[31:0]) else begin
          errors++;
          $display("CHECK FAILED at %0t: commit rd %0d value %h, expected rd %0d value %h",
                   $time, o_commit_rd, o_commit_value, exp_head[36:32], exp_head[31:0]);
        end
      end
    end
  end

  initial begin
    wait (planned > 0);
    repeat (20 * planned + 200) @(posedge clk_100mhz);
    $display("timeout, %0d commits still outstanding after %0d cycles",
             expected.size(), 20 * planned + 200);
    $display("errors %0d, commits checked %0d", errors, commits);
    $display("TEST FAIL");
    $finish;
  end

  initial begin
    clk_100mhz   = 1'b0;
    sys_rst      = 1'b1;
    i_inst_valid = 1'b0;
    i_inst       = '0;
    errors       = 0;
    commits      = 0;
    planned      = 0;
    for (int r = 0; r < 32; r++) begin
      model_regs[r] = '0;
    end
    void'($urandom(9));
    build_directed();
    build_random(N_RANDOM);
    repeat (8) @(posedge clk_100mhz);
    #1;
    sys_rst = 1'b0;
    planned = prog_inst.size();
    repeat (4) begin
      @(posedge clk_100mhz);  // idle, nothing may commit yet
    end
    #1;
    for (int k = 0; k < prog_inst.size(); k++) begin
      send(prog_inst[k], prog_gap[k]);
    end
    while (expected.size() != 0) begin
      @(negedge clk_100mhz);
    end
    repeat (10) @(negedge clk_100mhz);  // catch stray commits
    $display("errors %0d, commits checked %0d", errors, commits);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- bench/ooo_core_assert.sv
`timescale 1ns/1ps
`default_nettype none

module ooo_core_assert (
  input wire                 clk_100mhz,
  input wire                 sys_rst,
  input wire                 i_inst_ready,
  input wire                 i_commit_valid,
  input wire ooo_pkg::word_t i_commit_value
);

  // state clears at the first reset edge, so look one cycle later
  no_commit_in_reset: assert property (
    @(posedge clk_100mhz) sys_rst |=> !i_commit_valid
  ) else $error("commit seen while in reset or right after it");

  known_commit_value: assert property (
    @(posedge clk_100mhz) disable iff (sys_rst) i_commit_valid |-> !$isunknown(i_commit_value)
  ) else $error("commit value has unknown bits");

  ready_after_reset: assert property (
    @(posedge clk_100mhz) $fell(sys_rst) |-> i_inst_ready
  ) else $error("instruction ready low in first cycle after reset");

endmodule

bind ooo_core_top ooo_core_assert u_core_assert (
  .clk_100mhz     (clk_100mhz),
  .sys_rst        (sys_rst),
  .i_inst_ready   (o_inst_ready),
  .i_commit_valid (o_commit_valid),
  .i_commit_value (o_commit_value)
);

`default_nettype wire

//--- src/ooo_core_top.sv
`timescale 1ns/1ps
`default_nettype none

module ooo_core_top #(
  parameter int ROB_SIZE = ooo_pkg::DEFAULT_ROB_SIZE,
  parameter int RS_DEPTH = ooo_pkg::DEFAULT_RS_DEPTH
) (
  input  wire                 clk_100mhz,
  input  wire                 sys_rst,
  input  wire                 i_inst_valid,
  input  wire ooo_pkg::word_t i_inst,
  output logic                o_inst_ready,
  output logic                o_commit_valid,
  output ooo_pkg::reg_addr_t  o_commit_rd,
  output ooo_pkg::word_t      o_commit_value
);

  localparam int IX_W = $clog2(ROB_SIZE);

  logic               rob_full;
  logic [IX_W-1:0]    rob_tail;
  logic               rs_space;
  ooo_pkg::word_t     rf_val1;
  ooo_pkg::word_t     rf_val2;
  logic [IX_W-1:0]    rf_tag1;
  logic [IX_W-1:0]    rf_tag2;
  logic               rf_busy1;
  logic               rf_busy2;
  logic               rob_ready1;
  logic               rob_ready2;
  ooo_pkg::word_t     rob_val1;
  ooo_pkg::word_t     rob_val2;
  ooo_pkg::reg_addr_t rs1;
  ooo_pkg::reg_addr_t rs2;
  logic               alloc;
  ooo_pkg::reg_addr_t alloc_rd;
  logic [IX_W-1:0]    commit_ix;
  logic               cdb_valid;  // single producer, no arbitration
  logic [IX_W-1:0]    cdb_rob_ix;
  ooo_pkg::word_t     cdb_value;

  issue_if #(.ROB_SIZE(ROB_SIZE)) dispatch ();

  issue_unit #(.ROB_SIZE(ROB_SIZE)) u_issue (
    .i_inst_valid (i_inst_valid), .i_inst       (i_inst),
    .i_rob_full   (rob_full),     .i_rob_tail   (rob_tail),
    .i_rs_space   (rs_space),
    .i_rf_val1    (rf_val1),      .i_rf_val2    (rf_val2),
    .i_rf_tag1    (rf_tag1),      .i_rf_tag2    (rf_tag2),
    .i_rf_busy1   (rf_busy1),     .i_rf_busy2   (rf_busy2),
    .i_rob_ready1 (rob_ready1),   .i_rob_ready2 (rob_ready2),
    .i_rob_val1   (rob_val1),     .i_rob_val2   (rob_val2),
    .o_inst_ready (o_inst_ready),
    .o_rs1        (rs1),          .o_rs2        (rs2),
    .o_alloc      (alloc),        .o_alloc_rd   (alloc_rd),
    .iss          (dispatch.issuer)
  );

  reg_status_file #(.ROB_SIZE(ROB_SIZE)) u_regs (
    .clk_100mhz     (clk_100mhz),     .sys_rst     (sys_rst),
    .i_rs1          (rs1),            .i_rs2       (rs2),
    .i_alloc        (alloc),          .i_alloc_rd  (alloc_rd),
    .i_alloc_ix     (rob_tail),
    .i_commit       (o_commit_valid), .i_commit_rd (o_commit_rd),
    .i_commit_value (o_commit_value), .i_commit_ix (commit_ix),
    .o_val1         (rf_val1),        .o_val2      (rf_val2),
    .o_tag1         (rf_tag1),        .o_tag2      (rf_tag2),
    .o_busy1        (rf_busy1),       .o_busy2     (rf_busy2)
  );

  reorder_buffer #(.ROB_SIZE(ROB_SIZE)) u_rob (
    .clk_100mhz    (clk_100mhz),     .sys_rst        (sys_rst),
    .i_alloc       (alloc),          .i_alloc_rd     (alloc_rd),
    .i_cdb_valid   (cdb_valid),      .i_cdb_rob_ix   (cdb_rob_ix),
    .i_cdb_value   (cdb_value),
    .i_look_ix1    (rf_tag1),        .i_look_ix2     (rf_tag2),
    .o_full        (rob_full),       .o_tail         (rob_tail),
    .o_look_ready1 (rob_ready1),     .o_look_ready2  (rob_ready2),
    .o_look_val1   (rob_val1),       .o_look_val2    (rob_val2),
    .o_commit      (o_commit_valid), .o_commit_rd    (o_commit_rd),
    .o_commit_value(o_commit_value), .o_commit_ix    (commit_ix)
  );

  alu_station #(.ROB_SIZE(ROB_SIZE), .RS_DEPTH(RS_DEPTH)) u_alu_rs (
    .clk_100mhz   (clk_100mhz),
    .sys_rst      (sys_rst),
    .iss          (dispatch.station),
    .o_rs_space   (rs_space),
    .o_cdb_valid  (cdb_valid),
    .o_cdb_rob_ix (cdb_rob_ix),
    .o_cdb_value  (cdb_value)
  );

endmodule

`default_nettype wire

//--- src/alu_station.sv
`timescale 1ns/1ps
`default_nettype none

module alu_station #(
  parameter int ROB_SIZE = 8,
  parameter int RS_DEPTH = 4
) (
  input  wire                         clk_100mhz,
  input  wire                         sys_rst,
  issue_if.station                    iss,
  output logic                        o_rs_space,
  output logic                        o_cdb_valid,
  output logic [$clog2(ROB_SIZE)-1:0] o_cdb_rob_ix,
  output ooo_pkg::word_t              o_cdb_value
);

  localparam int IX_W  = $clog2(ROB_SIZE);
  localparam int SEL_W = (RS_DEPTH > 1) ? $clog2(RS_DEPTH) : 1;

  logic [RS_DEPTH-1:0] busy;
  logic [RS_DEPTH-1:0] rdy_i;
  logic [RS_DEPTH-1:0] rdy_j;
  isa_pkg::alu_func_e  ent_func [RS_DEPTH];
  logic [IX_W-1:0]     ent_rob  [RS_DEPTH];
  logic [IX_W-1:0]     ent_qi   [RS_DEPTH];
  logic [IX_W-1:0]     ent_qj   [RS_DEPTH];
  ooo_pkg::word_t      ent_vi   [RS_DEPTH];
  ooo_pkg::word_t      ent_vj   [RS_DEPTH];

  logic                free_sel_valid;
  logic [SEL_W-1:0]    free_sel;
  logic                ex_hit;
  logic [SEL_W-1:0]    ex_sel;
  logic                cdb_hit_i;  // incoming operand arrives on the bus now
  logic                cdb_hit_j;
  ooo_pkg::word_t      op_a;
  ooo_pkg::word_t      op_b;
  ooo_pkg::word_t      result;

  assign o_rs_space = free_sel_valid;
  assign cdb_hit_i  = o_cdb_valid && (o_cdb_rob_ix == iss.qi);
  assign cdb_hit_j  = o_cdb_valid && (o_cdb_rob_ix == iss.qj);

  // lowest free slot and lowest slot ready to run
  always_comb begin
    free_sel_valid = 1'b0;
    free_sel       = '0;
    ex_hit         = 1'b0;
    ex_sel         = '0;
    for (int e = RS_DEPTH - 1; e >= 0; e--) begin
      if (!busy[e]) begin
        free_sel_valid = 1'b1;
        free_sel       = SEL_W'(e);
      end
      if (busy[e] && rdy_i[e] && rdy_j[e]) begin
        ex_hit = 1'b1;
        ex_sel = SEL_W'(e);
      end
    end
  end

  assign op_a = ent_vi[ex_sel];
  assign op_b = ent_vj[ex_sel];

  always_comb begin
    case (ent_func[ex_sel])
      isa_pkg::ADD:    result = op_a + op_b;
      isa_pkg::SUB:    result = op_a - op_b;
      isa_pkg::AND:    result = op_a & op_b;
      isa_pkg::OR:     result = op_a | op_b;
      isa_pkg::XOR:    result = op_a ^ op_b;
      isa_pkg::SLL:    result = op_a << op_b[4:0];
      isa_pkg::SRL:    result = op_a >> op_b[4:0];
      isa_pkg::SRA:    result = $signed(op_a) >>> op_b[4:0];
      isa_pkg::SLT:    result = ooo_pkg::word_t'($signed(op_a) < $signed(op_b));
      isa_pkg::SLTU:   result = ooo_pkg::word_t'(op_a < op_b);
      isa_pkg::PASS_B: result = op_b;
      default:         result = '0;
    endcase
  end

  always_ff @(posedge clk_100mhz) begin
    if (sys_rst) begin
      busy        <= '0;
      o_cdb_valid <= 1'b0;
    end else begin
      if (ex_hit) begin
        busy[ex_sel] <= 1'b0;  // slot frees as it leaves for the alu
      end
      if (iss.valid) begin
        busy[free_sel] <= 1'b1;
      end
      o_cdb_valid <= ex_hit;
    end
  end

  always_ff @(posedge clk_100mhz) begin
    // snoop the bus for waiting operands
    for (int e = 0; e < RS_DEPTH; e++) begin
      if (o_cdb_valid && !rdy_i[e] && ent_qi[e] == o_cdb_rob_ix) begin
        ent_vi[e] <= o_cdb_value;
        rdy_i[e]  <= 1'b1;
      end
      if (o_cdb_valid && !rdy_j[e] && ent_qj[e] == o_cdb_rob_ix) begin
        ent_vj[e] <= o_cdb_value;
        rdy_j[e]  <= 1'b1;
      end
    end
    if (iss.valid) begin
      ent_func[free_sel] <= iss.func;
      ent_rob[free_sel]  <= iss.rob_ix;
      ent_qi[free_sel]   <= iss.qi;
      ent_qj[free_sel]   <= iss.qj;
      ent_vi[free_sel]   <= iss.i_ready ? iss.vi : o_cdb_value;
      ent_vj[free_sel]   <= iss.j_ready ? iss.vj : o_cdb_value;
      rdy_i[free_sel]    <= iss.i_ready || cdb_hit_i;
      rdy_j[free_sel]    <= iss.j_ready || cdb_hit_j;
    end
    if (ex_hit) begin
      o_cdb_rob_ix <= ent_rob[ex_sel];
      o_cdb_value  <= result;
    end
  end

endmodule

`default_nettype wire

//--- src/reorder_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module reorder_buffer #(
  parameter int ROB_SIZE = 8
) (
  input  wire                         clk_100mhz,
  input  wire                         sys_rst,
  input  wire                         i_alloc,
  input  wire ooo_pkg::reg_addr_t     i_alloc_rd,
  input  wire                         i_cdb_valid,
  input  wire [$clog2(ROB_SIZE)-1:0]  i_cdb_rob_ix,
  input  wire ooo_pkg::word_t         i_cdb_value,
  input  wire [$clog2(ROB_SIZE)-1:0]  i_look_ix1,
  input  wire [$clog2(ROB_SIZE)-1:0]  i_look_ix2,
  output logic                        o_full,
  output logic [$clog2(ROB_SIZE)-1:0] o_tail,
  output logic                        o_look_ready1,
  output logic                        o_look_ready2,
  output ooo_pkg::word_t              o_look_val1,
  output ooo_pkg::word_t              o_look_val2,
  output logic                        o_commit,
  output ooo_pkg::reg_addr_t          o_commit_rd,
  output ooo_pkg::word_t              o_commit_value,
  output logic [$clog2(ROB_SIZE)-1:0] o_commit_ix
);

  localparam int IX_W  = $clog2(ROB_SIZE);
  localparam int CNT_W = IX_W + 1;

  ooo_pkg::reg_addr_t  ent_rd    [ROB_SIZE];
  ooo_pkg::word_t      ent_value [ROB_SIZE];
  logic [ROB_SIZE-1:0] ent_ready;            // result has arrived
  logic [IX_W-1:0]     head;
  logic [IX_W-1:0]     tail;
  logic [CNT_W-1:0]    count;

  // circular increment, also for sizes that are not a power of two
  function automatic logic [IX_W-1:0] bump(input logic [IX_W-1:0] ix);
    if (ix == IX_W'(ROB_SIZE - 1)) begin
      return '0;
    end
    return ix + 1'b1;
  endfunction

  assign o_full = (count == CNT_W'(ROB_SIZE));
  assign o_tail = tail;

  // operand lookups for the issue unit
  assign o_look_ready1 = ent_ready[i_look_ix1];
  assign o_look_ready2 = ent_ready[i_look_ix2];
  assign o_look_val1   = ent_value[i_look_ix1];
  assign o_look_val2   = ent_value[i_look_ix2];

  // head retires as soon as its result is in
  assign o_commit       = (count != '0) && ent_ready[head];
  assign o_commit_ix    = head;
  assign o_commit_rd    = ent_rd[head];
  assign o_commit_value = ent_value[head];

  always_ff @(posedge clk_100mhz) begin
    if (sys_rst) begin
      head      <= '0;
      tail      <= '0;
      count     <= '0;
      ent_ready <= '0;
    end else begin
      if (i_cdb_valid) begin
        ent_ready[i_cdb_rob_ix] <= 1'b1;
      end
      if (i_alloc) begin
        ent_ready[tail] <= 1'b0;
        tail            <= bump(tail);
      end
      if (o_commit) begin
        head <= bump(head);
      end
      count <= count + CNT_W'(i_alloc) - CNT_W'(o_commit);
    end
  end

  always_ff @(posedge clk_100mhz) begin
    if (i_alloc) begin
      ent_rd[tail] <= i_alloc_rd;
    end
    if (i_cdb_valid) begin
      ent_value[i_cdb_rob_ix] <= i_cdb_value;
    end
  end

endmodule

`default_nettype wire

//--- src/reg_status_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_status_file #(
  parameter int ROB_SIZE = 8
) (
  input  wire                         clk_100mhz,
  input  wire                         sys_rst,
  input  wire ooo_pkg::reg_addr_t     i_rs1,
  input  wire ooo_pkg::reg_addr_t     i_rs2,
  input  wire                         i_alloc,
  input  wire ooo_pkg::reg_addr_t     i_alloc_rd,
  input  wire [$clog2(ROB_SIZE)-1:0]  i_alloc_ix,
  input  wire                         i_commit,
  input  wire ooo_pkg::reg_addr_t     i_commit_rd,
  input  wire ooo_pkg::word_t         i_commit_value,
  input  wire [$clog2(ROB_SIZE)-1:0]  i_commit_ix,
  output ooo_pkg::word_t              o_val1,
  output ooo_pkg::word_t              o_val2,
  output logic [$clog2(ROB_SIZE)-1:0] o_tag1,
  output logic [$clog2(ROB_SIZE)-1:0] o_tag2,
  output logic                        o_busy1,
  output logic                        o_busy2
);

  localparam int NREG = 2 ** isa_pkg::REG_ADDR_W;
  localparam int IX_W = $clog2(ROB_SIZE);

  ooo_pkg::word_t  regs [NREG];
  logic [NREG-1:0] busy;
  logic [IX_W-1:0] tags [NREG];  // rob entry that will write the register

  // x0 is never written or marked busy, so it reads zero
  assign o_val1  = regs[i_rs1];
  assign o_val2  = regs[i_rs2];
  assign o_tag1  = tags[i_rs1];
  assign o_tag2  = tags[i_rs2];
  assign o_busy1 = busy[i_rs1];
  assign o_busy2 = busy[i_rs2];

  always_ff @(posedge clk_100mhz) begin
    if (sys_rst) begin
      for (int r = 0; r < NREG; r++) begin
        regs[r] <= '0;
      end
      busy <= '0;
    end else begin
      if (i_commit && i_commit_rd != '0) begin
        regs[i_commit_rd] <= i_commit_value;
        // younger writer still pending, keep it busy
        if (tags[i_commit_rd] == i_commit_ix) begin
          busy[i_commit_rd] <= 1'b0;
        end
      end
      if (i_alloc && i_alloc_rd != '0) begin
        busy[i_alloc_rd] <= 1'b1;  // wins over a same-cycle clear
      end
    end
  end

  always_ff @(posedge clk_100mhz) begin
    if (i_alloc && i_alloc_rd != '0) begin
      tags[i_alloc_rd] <= i_alloc_ix;
    end
  end

endmodule

`default_nettype wire

//--- src/issue_unit.sv
`timescale 1ns/1ps
`default_nettype none

module issue_unit #(
  parameter int ROB_SIZE = 8
) (
  input  wire                        i_inst_valid,
  input  wire ooo_pkg::word_t        i_inst,
  input  wire                        i_rob_full,
  input  wire [$clog2(ROB_SIZE)-1:0] i_rob_tail,
  input  wire                        i_rs_space,
  input  wire ooo_pkg::word_t        i_rf_val1,
  input  wire ooo_pkg::word_t        i_rf_val2,
  input  wire [$clog2(ROB_SIZE)-1:0] i_rf_tag1,
  input  wire [$clog2(ROB_SIZE)-1:0] i_rf_tag2,
  input  wire                        i_rf_busy1,
  input  wire                        i_rf_busy2,
  input  wire                        i_rob_ready1,
  input  wire                        i_rob_ready2,
  input  wire ooo_pkg::word_t        i_rob_val1,
  input  wire ooo_pkg::word_t        i_rob_val2,
  output logic                       o_inst_ready,
  output ooo_pkg::reg_addr_t         o_rs1,
  output ooo_pkg::reg_addr_t         o_rs2,
  output logic                       o_alloc,
  output ooo_pkg::reg_addr_t         o_alloc_rd,
  issue_if.issuer                    iss
);

  isa_pkg::opcode_e              opcode;
  logic [isa_pkg::FUNCT3_W-1:0]  funct3;
  logic                          alt;        // inst[30], sub and sra
  logic                          supported;
  logic                          use_imm;
  ooo_pkg::word_t                imm;

  assign opcode     = isa_pkg::opcode_e'(i_inst[isa_pkg::OPCODE_W-1:0]);
  assign funct3     = i_inst[12 +: isa_pkg::FUNCT3_W];
  assign alt        = i_inst[30];
  assign o_rs1      = i_inst[15 +: isa_pkg::REG_ADDR_W];
  assign o_rs2      = i_inst[20 +: isa_pkg::REG_ADDR_W];
  assign o_alloc_rd = i_inst[7 +: isa_pkg::REG_ADDR_W];

  // nops are taken under the same condition, they just allocate nothing
  assign o_inst_ready = !i_rob_full && i_rs_space;
  assign o_alloc      = i_inst_valid && supported && o_inst_ready;
  assign iss.valid    = o_alloc;
  assign iss.rob_ix   = i_rob_tail;
  assign iss.qi       = i_rf_tag1;
  assign iss.qj       = i_rf_tag2;

  always_comb begin
    supported = 1'b1;
    use_imm   = (opcode != isa_pkg::OP);
    imm       = {{20{i_inst[31]}}, i_inst[31:20]};  // i-type
    case (funct3)
      3'b000:  iss.func = (alt && opcode == isa_pkg::OP) ? isa_pkg::SUB : isa_pkg::ADD;
      3'b001:  iss.func = isa_pkg::SLL;
      3'b010:  iss.func = isa_pkg::SLT;
      3'b011:  iss.func = isa_pkg::SLTU;
      3'b100:  iss.func = isa_pkg::XOR;
      3'b101:  iss.func = alt ? isa_pkg::SRA : isa_pkg::SRL;
      3'b110:  iss.func = isa_pkg::OR;
      default: iss.func = isa_pkg::AND;
    endcase
    if (opcode == isa_pkg::LUI) begin
      iss.func = isa_pkg::PASS_B;
      imm      = {i_inst[31:12], 12'b0};
    end else if (opcode != isa_pkg::OP && opcode != isa_pkg::OPIMM) begin
      supported = 1'b0;
    end
  end

  // operand a: register, then rob entry, else wait on tag
  always_comb begin
    if (opcode == isa_pkg::LUI || !i_rf_busy1) begin
      iss.vi      = (opcode == isa_pkg::LUI) ? '0 : i_rf_val1;
      iss.i_ready = 1'b1;
    end else begin
      iss.vi      = i_rob_val1;
      iss.i_ready = i_rob_ready1;
    end
    if (use_imm) begin
      iss.vj      = imm;
      iss.j_ready = 1'b1;
    end else if (!i_rf_busy2) begin
      iss.vj      = i_rf_val2;
      iss.j_ready = 1'b1;
    end else begin
      iss.vj      = i_rob_val2;
      iss.j_ready = i_rob_ready2;
    end
  end

endmodule

`default_nettype wire

//--- src/issue_if.sv
`timescale 1ns/1ps
`default_nettype none

// one dispatched instruction, issue unit to alu station
interface issue_if #(
  parameter int ROB_SIZE = 8
);
  localparam int IX_W = $clog2(ROB_SIZE);

  logic                  valid;   // one-cycle strobe
  isa_pkg::alu_func_e    func;
  logic [IX_W-1:0]       rob_ix;  // destination entry
  ooo_pkg::word_t        vi;
  ooo_pkg::word_t        vj;
  logic [IX_W-1:0]       qi;      // producer tags when not ready
  logic [IX_W-1:0]       qj;
  logic                  i_ready;
  logic                  j_ready;

  modport issuer (output valid, func, rob_ix, vi, vj, qi, qj, i_ready, j_ready);
  modport station (input valid, func, rob_ix, vi, vj, qi, qj, i_ready, j_ready);

endinterface

`default_nettype wire

//--- src/ooo_pkg.sv
`default_nettype none

package ooo_pkg;

  typedef logic [31:0] word_t;
  typedef logic [isa_pkg::REG_ADDR_W-1:0] reg_addr_t;

  // default sizing for the top level
  localparam int DEFAULT_ROB_SIZE = 8;
  localparam int DEFAULT_RS_DEPTH = 4;

endpackage

`default_nettype wire

//--- src/isa_pkg.sv
`default_nettype none

package isa_pkg;

  // instruction field widths
  localparam int OPCODE_W   = 7;
  localparam int FUNCT3_W   = 3;
  localparam int REG_ADDR_W = 5;

  // major opcodes handled by the core, anything else is a nop
  typedef enum logic [OPCODE_W-1:0] {
    OP    = 7'b0110011,
    OPIMM = 7'b0010011,
    LUI   = 7'b0110111
  } opcode_e;

  typedef enum logic [3:0] {
    ADD,
    SUB,
    AND,
    OR,
    XOR,
    SLL,
    SRL,
    SRA,
    SLT,
    SLTU,
    PASS_B  // lui result is operand b
  } alu_func_e;

endpackage

`default_nettype wire
